/* Bender.yml */
package:
  name: sparc_seq

sources:
  - seqPkg.sv
  - seqIfs.sv
  - fetchUnit.sv
  - instrDecode.sv
  - condEval.sv
  - windowCtrl.sv
  - pcUnit.sv
  - seqFsm.sv
  - sparcSeq.sv
  - target: test
    files:
      - sparcSeq_assert.sv
      - sparcSeqTb.sv

/* build.f */
seqPkg.sv
seqIfs.sv
fetchUnit.sv
instrDecode.sv
condEval.sv
windowCtrl.sv
pcUnit.sv
seqFsm.sv
sparcSeq.sv
sparcSeq_assert.sv
sparcSeqTb.sv

/* condEval.sv */
// integer condition evaluation for Bicc and Ticc, Icc ordered N, Z, V, C
`timescale 1ns/1ps

module condEval (
        input  logic [3:0] cond,
        input  logic [3:0] Icc,
        output logic       taken
);
        logic neg, zero, ovf, carry;
        logic base;

        assign {neg, zero, ovf, carry} = Icc;

        always_comb
        begin
                case (cond[2:0])
                3'd0:    base = 1'b0; // never
                3'd1:    base = zero; // equal
                3'd2:    base = zero | (neg ^ ovf); // less or equal
                3'd3:    base = neg ^ ovf; // less
                3'd4:    base = carry | zero; // less or equal, unsigned
                3'd5:    base = carry; // carry set
                3'd6:    base = neg;
                default: base = ovf;
                endcase
        end

        // codes 8..15 are the complements of 0..7
        assign taken = base ^ cond[3];

endmodule

/* fetchUnit.sv */
// four-phase fetch; a new request only goes out after MemAck has been seen low
// MemAddr is held for the whole transaction
`timescale 1ns/1ps

module fetchUnit (
        input  logic                          Clk,
        input  logic                          rst,
        fetchIf.unit                          fetch,
        output logic                          MemReq,
        output logic [seqPkg::AddrWidth-1:0]  MemAddr,
        input  logic                          MemAck,
        input  logic [seqPkg::InstrWidth-1:0] MemData
);
        typedef enum logic [1:0] {phIdle, phReq, phRelease} phaseE;

        phaseE phase;

        always_ff @(posedge Clk)
        begin
                if (rst)
                begin
                        phase <= phIdle;
                        MemReq <= 1'b0;
                        fetch.done <= 1'b0;
                end
                else
                begin
                        fetch.done <= 1'b0;
                        case (phase)
                        phIdle:
                                if (fetch.start)
                                begin
                                        MemReq <= 1'b1;
                                        phase <= phReq;
                                end
                        phReq:
                                if (MemAck)
                                begin
                                        MemReq <= 1'b0; // data captured this edge
                                        phase <= phRelease;
                                end
                        default:
                                if (!MemAck)
                                begin
                                        fetch.done <= 1'b1;
                                        phase <= phIdle;
                                end
                        endcase
                end
        end

        always_ff @(posedge Clk)
        begin
                if (phase == phIdle && fetch.start)
                        MemAddr <= fetch.addr;
                if (phase == phReq && MemAck)
                        fetch.instr <= MemData;
        end

endmodule

/* instrDecode.sv */
// combinational decode of op/op2/op3; unlisted encodings become opIllegal
`timescale 1ns/1ps

module instrDecode (
        input  logic [seqPkg::InstrWidth-1:0]  instr,
        output seqPkg::opKindE                 kind,
        output logic [3:0]                     cond,
        output logic                           annul,
        output logic [seqPkg::Disp22Width-1:0] disp22,
        output logic [5:0]                     op3
);
        logic [1:0] op;
        logic [2:0] op2;

        assign op = instr[seqPkg::OpLsb +: 2];
        assign op2 = instr[seqPkg::Op2Lsb +: 3];
        assign op3 = instr[seqPkg::Op3Lsb +: 6];
        assign cond = instr[seqPkg::CondLsb +: 4]; // also the Ticc condition
        assign annul = instr[seqPkg::AnnulBit];
        assign disp22 = instr[seqPkg::Disp22Width-1:0];

        always_comb
        begin
                kind = seqPkg::opIllegal;
                if (op == seqPkg::OpFmt2 && op2 == seqPkg::Op2Bicc)
                        kind = seqPkg::opBranch;
                else if (op == seqPkg::OpFmt3)
                begin
                        case (op3)
                        seqPkg::Op3Save:    kind = seqPkg::opSave;
                        seqPkg::Op3Restore: kind = seqPkg::opRestore;
                        seqPkg::Op3Ticc:    kind = seqPkg::opTicc;
                        default:            kind = seqPkg::opIllegal;
                        endcase
                end
        end

endmodule

/* pcUnit.sv */
// PC/nPC pair with delayed branching and trap vectoring through TbaBase
// badTarget is valid whenever disp22 and pc are, independent of the command
`timescale 1ns/1ps

module pcUnit #(
        parameter int unsigned TbaBase = 32'h400,
        parameter int unsigned AddrLimit = 508
) (
        input  logic Clk,
        input  logic rst,
        pcUpdIf.unit pcUpd
);
        localparam int AddrW = seqPkg::AddrWidth;
        localparam int DispW = seqPkg::Disp22Width;

        logic [AddrW-1:0] branchTarget;
        logic [AddrW-1:0] trapVector;

        // word displacement, sign-extended
        assign branchTarget = pcUpd.pc
                + {{(AddrW - DispW - 2){pcUpd.disp22[DispW-1]}}, pcUpd.disp22, 2'b00};
        assign trapVector = AddrW'(TbaBase)
                + AddrW'(seqPkg::VectorStride) * AddrW'(pcUpd.tt);
        assign pcUpd.badTarget = branchTarget > AddrW'(AddrLimit);

        always_ff @(posedge Clk)
        begin
                if (rst)
                begin
                        pcUpd.pc <= '0;
                        pcUpd.npc <= AddrW'(4);
                end
                else
                begin
                        case (pcUpd.cmd)
                        seqPkg::updSeq:
                        begin
                                pcUpd.pc <= pcUpd.npc;
                                pcUpd.npc <= pcUpd.npc + AddrW'(4);
                        end
                        seqPkg::updBranch:
                        begin
                                pcUpd.pc <= pcUpd.npc; // delay slot still runs
                                pcUpd.npc <= branchTarget;
                        end
                        seqPkg::updAnnulSkip:
                        begin
                                pcUpd.pc <= pcUpd.npc + AddrW'(4);
                                pcUpd.npc <= pcUpd.npc + AddrW'(8);
                        end
                        seqPkg::updTrap:
                        begin
                                pcUpd.pc <= trapVector;
                                pcUpd.npc <= trapVector + AddrW'(4);
                        end
                        default:
                        begin
                                pcUpd.pc <= pcUpd.pc; // hold
                                pcUpd.npc <= pcUpd.npc;
                        end
                        endcase
                end
        end

endmodule

/* seqFsm.sv */
// one instruction in flight: fetch, decode, execute, plus one cycle for trap entry
// the trap cause is captured in execute and applied in the trap cycle
`timescale 1ns/1ps

module seqFsm (
        input  logic           Clk,
        input  logic           rst,
        fetchIf.fsm            fetch,
        pcUpdIf.ctrl           pcUpd,
        input  seqPkg::opKindE kind,
        input  logic           annul,
        input  logic           taken,
        input  logic           overflow,
        input  logic           underflow,
        output logic           save,
        output logic           restore,
        output logic           trapClr
);
        typedef enum logic [2:0] {stIdle, stFetch, stDecode, stExec, stTrap} stateE;

        stateE state;
        logic trapHit;
        seqPkg::trapTypeE trapNext;
        seqPkg::trapTypeE trapReg;

        assign fetch.addr = pcUpd.pc;
        assign pcUpd.tt = trapReg;

        always_comb
        begin
                pcUpd.cmd = seqPkg::updHold;
                save = 1'b0;
                restore = 1'b0;
                trapClr = 1'b0;
                trapHit = 1'b0;
                trapNext = seqPkg::ttIllegal;
                if (state == stExec)
                begin
                        pcUpd.cmd = seqPkg::updSeq;
                        case (kind)
                        seqPkg::opBranch:
                                if (taken && pcUpd.badTarget)
                                begin
                                        trapHit = 1'b1;
                                        trapNext = seqPkg::ttBadAddr;
                                end
                                else if (taken)
                                        pcUpd.cmd = seqPkg::updBranch;
                                else if (annul)
                                        pcUpd.cmd = seqPkg::updAnnulSkip; // skip delay slot
                        seqPkg::opSave:
                                if (overflow)
                                begin
                                        trapHit = 1'b1;
                                        trapNext = seqPkg::ttWinOverflow;
                                end
                                else
                                        save = 1'b1;
                        seqPkg::opRestore:
                                if (underflow)
                                begin
                                        trapHit = 1'b1;
                                        trapNext = seqPkg::ttWinUnderflow;
                                end
                                else
                                        restore = 1'b1;
                        seqPkg::opTicc:
                                if (taken)
                                begin
                                        trapHit = 1'b1;
                                        trapNext = seqPkg::ttSoftware;
                                end
                        default:
                                trapHit = 1'b1; // ttIllegal
                        endcase
                        if (trapHit)
                                pcUpd.cmd = seqPkg::updHold;
                end
                else if (state == stTrap)
                begin
                        pcUpd.cmd = seqPkg::updTrap;
                        trapClr = 1'b1;
                end
        end

        always_ff @(posedge Clk)
        begin
                if (rst)
                begin
                        state <= stIdle;
                        fetch.start <= 1'b0;
                end
                else
                begin
                        fetch.start <= 1'b0;
                        case (state)
                        stIdle:
                        begin
                                fetch.start <= 1'b1;
                                state <= stFetch;
                        end
                        stFetch:
                                if (fetch.done)
                                        state <= stDecode;
                        stDecode:
                                state <= stExec;
                        stExec:
                                if (trapHit)
                                        state <= stTrap;
                                else
                                begin
                                        fetch.start <= 1'b1; // pc already updated
                                        state <= stFetch;
                                end
                        default:
                        begin
                                fetch.start <= 1'b1;
                                state <= stFetch;
                        end
                        endcase
                end
        end

        always_ff @(posedge Clk)
        begin
                if (state == stExec)
                        trapReg <= trapNext;
        end

endmodule

/* seqIfs.sv */
// fetch and PC-update interfaces between the sequencer FSM and its units
`timescale 1ns/1ps

interface fetchIf;
        logic start; // one-cycle pulse from the FSM
        logic [seqPkg::AddrWidth-1:0] addr;
        logic done; // one-cycle pulse, instr is valid
        logic [seqPkg::InstrWidth-1:0] instr;

        modport fsm (output start, output addr, input done, input instr);
        modport unit (input start, input addr, output done, output instr);
endinterface

interface pcUpdIf;
        seqPkg::pcUpdE cmd;
        seqPkg::trapTypeE tt;
        logic [seqPkg::Disp22Width-1:0] disp22;
        logic [seqPkg::AddrWidth-1:0] pc;
        logic [seqPkg::AddrWidth-1:0] npc;
        logic badTarget; // branch would put nPC past the limit

        modport ctrl (
                output cmd,
                output tt,
                input pc,
                input npc,
                input badTarget
        );
        modport unit (
                input cmd,
                input tt,
                input disp22,
                output pc,
                output npc,
                output badTarget
        );
endinterface

/* seqPkg.sv */
// shared types and encodings for the SPARC-style control-flow sequencer
// only Bicc, SAVE, RESTORE and Ticc are decoded, everything else is illegal
package seqPkg;

        localparam int InstrWidth = 32;
        localparam int AddrWidth = 32;
        localparam int Disp22Width = 22;
        localparam int VectorStride = 16; // bytes per trap vector

        // instruction field positions
        localparam int OpLsb = 30; // op in [31:30]
        localparam int AnnulBit = 29;
        localparam int CondLsb = 25; // cond in [28:25]
        localparam int Op2Lsb = 22; // op2 in [24:22]
        localparam int Op3Lsb = 19; // op3 in [24:19]

        localparam logic [1:0] OpFmt2 = 2'b00; // branch format
        localparam logic [1:0] OpFmt3 = 2'b10; // arithmetic format
        localparam logic [2:0] Op2Bicc = 3'd2;
        localparam logic [5:0] Op3Save = 6'h3C;
        localparam logic [5:0] Op3Restore = 6'h3D;
        localparam logic [5:0] Op3Ticc = 6'h3A;

        typedef enum logic [2:0] {
                opBranch,
                opSave,
                opRestore,
                opTicc,
                opIllegal
        } opKindE;

        // value doubles as the vector index
        typedef enum logic [3:0] {
                ttIllegal = 4'd2,
                ttBadAddr = 4'd3,
                ttWinOverflow = 4'd5,
                ttWinUnderflow = 4'd6,
                ttSoftware = 4'd8
        } trapTypeE;

        typedef enum logic [2:0] {
                updHold,
                updSeq,
                updBranch,
                updAnnulSkip,
                updTrap
        } pcUpdE;

endpackage

/* sparcSeq.sv */
// sequencer top; Icc and Wim come from an external datapath
// AddrLimit bounds nPC after a taken branch only
`timescale 1ns/1ps

module sparcSeq #(
        parameter int          NWindows = 8,
        parameter int unsigned TbaBase = 32'h400,
        parameter int unsigned AddrLimit = 508
) (
        input  logic                          Clk,
        input  logic                          rst,
        output logic                          MemReq,
        output logic [seqPkg::AddrWidth-1:0]  MemAddr,
        input  logic                          MemAck,
        input  logic [seqPkg::InstrWidth-1:0] MemData,
        input  logic [3:0]                    Icc,
        input  logic [NWindows-1:0]           Wim,
        output logic [$clog2(NWindows)-1:0]   Cwp
);
        seqPkg::opKindE kind;
        logic [3:0] cond;
        logic annul;
        logic taken;
        logic overflow;
        logic underflow;
        logic save;
        logic restore;
        logic trapClr;

        fetchIf fetchBus ();
        pcUpdIf pcBus ();

        seqFsm uFsm (
                .Clk       (Clk),
                .rst       (rst),
                .fetch     (fetchBus.fsm),
                .pcUpd     (pcBus.ctrl),
                .kind      (kind),
                .annul     (annul),
                .taken     (taken),
                .overflow  (overflow),
                .underflow (underflow),
                .save      (save),
                .restore   (restore),
                .trapClr   (trapClr)
        );

        fetchUnit uFetch (
                .Clk     (Clk),
                .rst     (rst),
                .fetch   (fetchBus.unit),
                .MemReq  (MemReq),
                .MemAddr (MemAddr),
                .MemAck  (MemAck),
                .MemData (MemData)
        );

        instrDecode uDecode (
                .instr  (fetchBus.instr),
                .kind   (kind),
                .cond   (cond),
                .annul  (annul),
                .disp22 (pcBus.disp22), // straight into the PC adder
                .op3    ()
        );

        condEval uCond (
                .cond  (cond),
                .Icc   (Icc),
                .taken (taken)
        );

        windowCtrl #(.NWindows(NWindows)) uWindow (
                .Clk       (Clk),
                .rst       (rst),
                .save      (save),
                .restore   (restore),
                .trapClr   (trapClr),
                .Wim       (Wim),
                .Cwp       (Cwp),
                .overflow  (overflow),
                .underflow (underflow)
        );

        pcUnit #(.TbaBase(TbaBase), .AddrLimit(AddrLimit)) uPc (
                .Clk   (Clk),
                .rst   (rst),
                .pcUpd (pcBus.unit)
        );

endmodule

/* sparcSeqTb.sv */
// directed testbench for sparcSeq; the memory model is 512 words with random stalls per phase
// unwritten words hold never-taken branches tagged by address, so code falls through in order
`timescale 1ns/1ps

module sparcSeqTb;
        localparam int NWin = 8;
        localparam int unsigned Tba = 32'h400;
        localparam int unsigned Limit = 508;
        localparam int CwpW = $clog2(NWin);
        localparam int AddrW = seqPkg::AddrWidth;
        localparam int VecBytes = 16;
        localparam int CycleLimit = 4000; // tests need roughly 1300 cycles
        localparam logic [5:0] SaveOp3 = 6'h3C;
        localparam logic [5:0] RestoreOp3 = 6'h3D;

        logic Clk;
        logic rst;
        logic MemReq;
        logic [AddrW-1:0] MemAddr;
        logic MemAck;
        logic [seqPkg::InstrWidth-1:0] MemData;
        logic [3:0] Icc;
        logic [NWin-1:0] Wim;
        logic [CwpW-1:0] Cwp;

        logic [seqPkg::InstrWidth-1:0] mem [0:511];
        logic [AddrW-1:0] fetchQ [$]; // addresses seen by the responder
        logic [AddrW-1:0] mPc;
        logic [AddrW-1:0] mNpc;
        logic [CwpW-1:0] mCwp;
        int cycles;
        int errCount;
        int unsigned seedInit;

        sparcSeq #(.NWindows(NWin), .TbaBase(Tba), .AddrLimit(Limit)) dut (
                .Clk     (Clk),
                .rst     (rst),
                .MemReq  (MemReq),
                .MemAddr (MemAddr),
                .MemAck  (MemAck),
                .MemData (MemData),
                .Icc     (Icc),
                .Wim     (Wim),
                .Cwp     (Cwp)
        );

        always #50 Clk = ~Clk;

        always @(posedge Clk)
        begin
                cycles <= cycles + 1;
                if (cycles >= CycleLimit)
                begin
                        $display("Timeout: the DUT stopped making progress after %0d cycles",
                                 CycleLimit);
                        $display("Regression failed");
                        $fatal(1, "cycle limit reached");
                end
                else if (dut.uReqAckChecks.failCount != 0)
                begin
                        $display("A handshake assertion on the memory bus failed");
                        $display("Regression failed");
                        $fatal(1, "assertion failure");
                end
        end

        // four-phase responder with 0..3 stall cycles before ack and before release
        always
        begin
                @(posedge Clk);
                #1;
                if (!rst && MemReq && !MemAck)
                begin
                        fetchQ.push_back(MemAddr);
                        repeat ($urandom_range(0, 3)) @(posedge Clk);
                        #1;
                        MemData = mem[MemAddr[10:2]];
                        MemAck = 1'b1;
                        while (MemReq)
                        begin
                                @(posedge Clk);
                                #1;
                        end
                        repeat ($urandom_range(0, 3)) @(posedge Clk);
                        #1;
                        MemAck = 1'b0;
                end
        end

        function automatic logic [31:0] makeBranch(input logic [3:0] cond, input logic a,
                                                    input logic [21:0] disp);
                return {2'b00, a, cond, 3'b010, disp};
        endfunction

        function automatic logic [31:0] makeWindowOp(input logic [5:0] op3);
                return {2'b10, 5'd0, op3, 19'd0};
        endfunction

        function automatic logic [31:0] makeTrapOp(input logic [3:0] cond);
                return {2'b10, 1'b0, cond, 6'h3A, 19'd0};
        endfunction

        // integer condition table over icc {N, Z, V, C}
        function automatic logic refTaken(input logic [3:0] cond, input logic [3:0] icc);
                logic n, z, v, c;
                {n, z, v, c} = icc;
                case (cond)
                4'h0:    return 1'b0; // bn
                4'h1:    return z; // be
                4'h2:    return z || (n != v); // ble
                4'h3:    return n != v; // bl
                4'h4:    return c || z; // bleu
                4'h5:    return c; // bcs
                4'h6:    return n; // bneg
                4'h7:    return v; // bvs
                4'h8:    return 1'b1; // ba
                4'h9:    return !z; // bne
                4'hA:    return !z && (n == v); // bg
                4'hB:    return n == v; // bge
                4'hC:    return !c && !z; // bgu
                4'hD:    return !c; // bcc
                4'hE:    return !n; // bpos
                default: return !v; // bvc
                endcase
        endfunction

        function automatic logic [CwpW-1:0] wrapCwp(input logic [CwpW-1:0] cwp, input logic up);
                int next;
                if (up)
                        next = (int'(cwp) + 1) % NWin;
                else
                        next = (int'(cwp) + NWin - 1) % NWin;
                return CwpW'(next);
        endfunction

        task automatic checkAddr(input logic [AddrW-1:0] got, input logic [AddrW-1:0] exp,
                                 input string what);
                if (got !== exp)
                begin
                        errCount++;
                        $display("Error at %0t: %s fetched %h, expected %h", $time, what, got, exp);
                        $display("Regression failed");
                        $fatal(1, "fetch address mismatch");
                end
        endtask

        task automatic checkCwp(input logic [CwpW-1:0] got, input logic [CwpW-1:0] exp,
                                input string what);
                if (got !== exp)
                begin
                        errCount++;
                        $display("Error at %0t: %s Cwp is %0d, expected %0d", $time, what, got, exp);
                        $display("Regression failed");
                        $fatal(1, "window pointer mismatch");
                end
        endtask

        task automatic expectFetch(input string what);
                logic [AddrW-1:0] got;
                while (fetchQ.size() == 0)
                        @(posedge Clk);
                got = fetchQ.pop_front();
                checkAddr(got, mPc, what);
        endtask

        task automatic stepSeq();
                mPc = mNpc;
                mNpc = mNpc + 4;
        endtask

        task automatic stepBranch(input logic [21:0] disp);
                int byteOffset;
                logic [AddrW-1:0] target;
                byteOffset = 4 * int'($signed(disp));
                target = mPc + AddrW'(byteOffset); // relative to the branch itself
                mPc = mNpc;
                mNpc = target;
        endtask

        task automatic stepAnnul();
                mPc = mNpc + 4;
                mNpc = mNpc + 8;
        endtask

        task automatic stepTrap(input seqPkg::trapTypeE tt);
                mPc = Tba + VecBytes * int'(tt);
                mNpc = mPc + 4;
        endtask

        task automatic clearMem();
                for (int i = 0; i < 512; i++)
                        mem[i] = makeBranch(4'h0, 1'b0, 22'(i * 3 + 1));
        endtask

        task automatic applyReset(input logic [3:0] icc, input logic [NWin-1:0] wim);
                @(posedge Clk);
                #1;
                rst = 1'b1;
                Icc = icc;
                Wim = wim;
                repeat (8) @(posedge Clk);
                #1;
                rst = 1'b0;
                fetchQ.delete();
                mPc = '0;
                mNpc = 32'd4;
                mCwp = '0;
        endtask

        task automatic testWindowRun();
                clearMem();
                for (int i = 0; i < 3; i++)
                        mem[i] = makeWindowOp(RestoreOp3);
                for (int i = 3; i < 7; i++)
                        mem[i] = makeWindowOp(SaveOp3);
                applyReset(4'h0, '0);
                for (int i = 0; i < 8; i++)
                begin
                        expectFetch("window run");
                        checkCwp(Cwp, mCwp, "window run");
                        if (i < 3)
                                mCwp = wrapCwp(mCwp, 1'b1);
                        else if (i < 7)
                                mCwp = wrapCwp(mCwp, 1'b0); // last save wraps to NWin-1
                        stepSeq();
                end
        endtask

        task automatic testBranchConds();
                logic [3:0] icc;
                for (int c = 0; c < 16; c++)
                begin
                        icc = 4'($urandom);
                        clearMem();
                        mem[0] = makeBranch(4'(c), 1'b0, 22'd6); // target 24
                        applyReset(icc, '0);
                        expectFetch("branch");
                        if (refTaken(4'(c), icc))
                                stepBranch(22'd6);
                        else
                                stepSeq();
                        expectFetch("delay slot");
                        stepSeq();
                        expectFetch("after delay slot");
                end
        endtask

        task automatic testAnnulAndBadAddr();
                clearMem();
                mem[0] = makeBranch(4'h0, 1'b1, 22'd6); // bn,a
                mem[3] = makeBranch(4'h8, 1'b0, 22'd200); // ba to 812
                applyReset(4'h0, '0);
                expectFetch("annulled branch");
                stepAnnul();
                expectFetch("past annulled slot");
                stepSeq();
                expectFetch("far branch");
                stepTrap(seqPkg::ttBadAddr);
                expectFetch("bad address vector");
        endtask

        task automatic testWindowTraps();
                clearMem();
                mem[0] = makeWindowOp(RestoreOp3);
                mem[1] = makeWindowOp(SaveOp3);
                mem[2] = makeWindowOp(SaveOp3); // onto window 7
                applyReset(4'h0, 8'h80);
                expectFetch("restore");
                mCwp = wrapCwp(mCwp, 1'b1);
                stepSeq();
                expectFetch("save");
                checkCwp(Cwp, mCwp, "after restore");
                mCwp = wrapCwp(mCwp, 1'b0);
                stepSeq();
                expectFetch("overflowing save");
                checkCwp(Cwp, mCwp, "after save");
                stepTrap(seqPkg::ttWinOverflow);
                expectFetch("overflow vector");
                checkCwp(Cwp, 3'd0, "overflow trap");

                clearMem();
                mem[0] = makeWindowOp(RestoreOp3);
                mem[1] = makeWindowOp(RestoreOp3); // onto window 2
                applyReset(4'h0, 8'h04);
                expectFetch("restore");
                mCwp = wrapCwp(mCwp, 1'b1);
                stepSeq();
                expectFetch("underflowing restore");
                checkCwp(Cwp, mCwp, "after restore");
                stepTrap(seqPkg::ttWinUnderflow);
                expectFetch("underflow vector");
                checkCwp(Cwp, 3'd0, "underflow trap");
        endtask

        task automatic testTicc();
                clearMem();
                mem[0] = makeTrapOp(4'h0); // tn
                mem[1] = makeTrapOp(4'h8); // ta
                applyReset(4'h0, '0);
                expectFetch("untaken ticc");
                stepSeq();
                expectFetch("taken ticc");
                stepTrap(seqPkg::ttSoftware);
                expectFetch("software trap vector");

                clearMem();
                mem[0] = 32'hC000_0000; // load format, not decoded
                applyReset(4'h0, '0);
                expectFetch("unknown encoding");
                stepTrap(seqPkg::ttIllegal);
                expectFetch("illegal vector");
        endtask

        initial
        begin
                seedInit = $urandom(70469);
                Clk = 1'b0;
                rst = 1'b1;
                MemAck = 1'b0;
                MemData = '0;
                Icc = '0;
                Wim = '0;
                cycles = 0;
                errCount = 0;
                mPc = '0;
                mNpc = 32'd4;
                mCwp = '0;
                clearMem();
                testWindowRun();
                testBranchConds();
                testAnnulAndBadAddr();
                testWindowTraps();
                testTicc();
                if (errCount == 0 && dut.uReqAckChecks.failCount == 0)
                begin
                        $display("Regression passed");
                        $finish;
                end
                else
                begin
                        $display("Regression failed");
                        $fatal(1, "errors were found during the run");
                end
        end

endmodule

/* sparcSeq_assert.sv */
// handshake and reset properties bound onto every sparcSeq instance
`timescale 1ns/1ps

module reqAckChecks (
        input logic                         Clk,
        input logic                         rst,
        input logic                         MemReq,
        input logic                         MemAck,
        input logic [seqPkg::AddrWidth-1:0] MemAddr
);
        int failCount = 0; // number of failed assertions

        resetLow: assert property (@(posedge Clk) rst |=> !MemReq)
        else
        begin
                $error("MemReq high during reset");
                failCount++;
        end

        addrStable: assert property (@(posedge Clk) disable iff (rst)
                (MemReq && $past(MemReq)) |-> $stable(MemAddr))
        else
        begin
                $error("MemAddr changed during a request");
                failCount++;
        end

        // a new request needs the previous ack released
        noRiseOnAck: assert property (@(posedge Clk) disable iff (rst)
                $rose(MemReq) |-> !$past(MemAck))
        else
        begin
                $error("MemReq rose while MemAck was high");
                failCount++;
        end

endmodule

bind sparcSeq reqAckChecks uReqAckChecks (
        .Clk     (Clk),
        .rst     (rst),
        .MemReq  (MemReq),
        .MemAck  (MemAck),
        .MemAddr (MemAddr)
);

/* windowCtrl.sv */
// current window pointer; SAVE steps down, RESTORE steps up, both modulo NWindows
// a step onto a set WIM bit is refused and reported as overflow or underflow
`timescale 1ns/1ps

module windowCtrl #(
        parameter int NWindows = 8
) (
        input  logic                        Clk,
        input  logic                        rst,
        input  logic                        save,
        input  logic                        restore,
        input  logic                        trapClr,
        input  logic [NWindows-1:0]         Wim,
        output logic [$clog2(NWindows)-1:0] Cwp,
        output logic                        overflow,
        output logic                        underflow
);
        localparam int CwpW = $clog2(NWindows);

        logic [CwpW-1:0] cwpDec;
        logic [CwpW-1:0] cwpInc;

        assign cwpDec = (Cwp == '0) ? CwpW'(NWindows - 1) : Cwp - 1'b1;
        assign cwpInc = (Cwp == CwpW'(NWindows - 1)) ? '0 : Cwp + 1'b1;
        assign overflow = Wim[cwpDec];
        assign underflow = Wim[cwpInc];

        always_ff @(posedge Clk)
        begin
                if (rst)
                        Cwp <= '0;
                else if (trapClr)
                        Cwp <= '0; // trap entry
                else if (save && !overflow)
                        Cwp <= cwpDec;
                else if (restore && !underflow)
                        Cwp <= cwpInc;
        end

endmodule
